//--- riscv_pkg.sv
// ISA-level widths and types for an RV64 core.
// Only the encodings that the commit path decodes are listed here.
package riscv_pkg;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int INST_W     = 32;

    typedef logic [XLEN-1:0]       pc_t;
    typedef logic [XLEN-1:0]       data_t;
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // SYSTEM opcode, funct12 = 1.
    localparam inst_t EBREAK_INST = 32'h0010_0073;

endpackage

//--- commit_pkg.sv
// Commit buffer records and default sizes.
// Entry and completion records are packed, so they can cross ports whole.
package commit_pkg;

    localparam int DEFAULT_DEPTH = 8;
    localparam int NUM_WB_PORTS  = 3;

    // One completion from a writeback port, matched by PC.
    typedef struct packed {
        logic                 valid;
        riscv_pkg::pc_t       pc;
        logic                 wena;
        riscv_pkg::reg_addr_t addr;
        riscv_pkg::data_t     data;
    } wb_result_t;

    // One buffer entry as seen at the head.
    typedef struct packed {
        logic                 valid;
        logic                 done;
        riscv_pkg::pc_t       pc;
        riscv_pkg::inst_t     inst;
        logic                 wena;
        riscv_pkg::reg_addr_t addr;
        riscv_pkg::data_t     data;
    } commit_entry_t;

    typedef logic [31:0] count_t;

endpackage

//--- commit_head_if.sv
// Head-of-buffer view shared by the buffer, the retire FSM and the status block.
// pop is a single-cycle strobe, sampled at the rising edge of clk.
`timescale 1ns/1ns

interface commit_head_if;

    import commit_pkg::*;

    logic          head_valid;
    logic          head_done;
    commit_entry_t head_entry;
    logic          pop;

    modport buffer (
        output head_valid,
        output head_done,
        output head_entry,
        input  pop
    );

    modport retire (
        input  head_valid,
        input  head_done,
        input  head_entry,
        output pop
    );

    // Passive view for the status block.
    modport monitor (
        input head_valid,
        input head_done,
        input head_entry,
        input pop
    );

endinterface

//--- commit_buffer.sv
// Circular commit buffer with two dispatch slots and PC-matched completion.
// DEPTH must be a power of two, 4 or more. Slot 0 is older than slot 1.
// Allocated PCs must be unique while they are in the buffer.
// alloc_ready comes from the registered fill level only.
`timescale 1ns/1ns

module commit_buffer #(
    parameter int DEPTH = commit_pkg::DEFAULT_DEPTH
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    disp_valid [2],
    input  riscv_pkg::pc_t          disp_pc    [2],
    input  riscv_pkg::inst_t        disp_inst  [2],
    output logic                    alloc_ready,
    input  commit_pkg::wb_result_t  wb [commit_pkg::NUM_WB_PORTS],
    commit_head_if.buffer           head
);

    import riscv_pkg::*;
    import commit_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   cnt_t;

    localparam cnt_t ALLOC_LIMIT = cnt_t'(DEPTH - 2);

    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0] done_q;
    ptr_t             head_ptr;
    ptr_t             tail_ptr;
    cnt_t             count_q;

    pc_t              pc_q   [DEPTH];
    inst_t            inst_q [DEPTH];
    logic             wena_q [DEPTH];
    reg_addr_t        addr_q [DEPTH];
    data_t            data_q [DEPTH];

    logic [1:0]       fire;
    logic [1:0]       n_alloc;
    ptr_t             slot_ptr [2];
    logic [DEPTH-1:0] pc_match [NUM_WB_PORTS];
    logic [DEPTH-1:0] hit      [NUM_WB_PORTS];
    logic [DEPTH-1:0] done_set;

    assign alloc_ready = (count_q <= ALLOC_LIMIT);  // Two or more entries free.

    assign fire[0]     = alloc_ready & disp_valid[0];
    assign fire[1]     = alloc_ready & disp_valid[1];
    assign n_alloc     = {1'b0, fire[0]} + {1'b0, fire[1]};
    assign slot_ptr[0] = tail_ptr;
    assign slot_ptr[1] = tail_ptr + ptr_t'(1);

    always_comb begin
        done_set = '0;
        for (int p = 0; p < NUM_WB_PORTS; p++) begin
            for (int i = 0; i < DEPTH; i++) begin
                pc_match[p][i] = wb[p].valid & valid_q[i] & (pc_q[i] == wb[p].pc);
                hit[p][i]      = pc_match[p][i] & ~done_q[i];
            end
            done_set = done_set | hit[p];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q  <= '0;
            done_q   <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
            count_q  <= '0;
        end else begin
            done_q <= done_q | done_set;
            if (head.pop) begin
                valid_q[head_ptr] <= 1'b0;
                done_q[head_ptr]  <= 1'b0;
                head_ptr          <= head_ptr + ptr_t'(1);
            end
            for (int s = 0; s < 2; s++) begin
                if (fire[s]) begin
                    valid_q[slot_ptr[s]] <= 1'b1;
                    done_q[slot_ptr[s]]  <= 1'b0;
                end
            end
            tail_ptr <= tail_ptr + ptr_t'(n_alloc);
            count_q  <= count_q + cnt_t'(n_alloc) - cnt_t'(head.pop);
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++) begin
            if (fire[s]) begin
                pc_q[slot_ptr[s]]   <= disp_pc[s];
                inst_q[slot_ptr[s]] <= disp_inst[s];
            end
        end
        for (int i = 0; i < DEPTH; i++) begin
            for (int p = 0; p < NUM_WB_PORTS; p++) begin
                if (hit[p][i]) begin
                    wena_q[i] <= wb[p].wena;
                    addr_q[i] <= wb[p].addr;
                    data_q[i] <= wb[p].data;
                end
            end
        end
    end

    assign head.head_valid = valid_q[head_ptr];
    assign head.head_done  = valid_q[head_ptr] & done_q[head_ptr];
    assign head.head_entry = '{
        valid: valid_q[head_ptr],
        done:  done_q[head_ptr],
        pc:    pc_q[head_ptr],
        inst:  inst_q[head_ptr],
        wena:  wena_q[head_ptr],
        addr:  addr_q[head_ptr],
        data:  data_q[head_ptr]
    };

    // Dispatch must respect alloc_ready.
    a_no_alloc_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        (disp_valid[0] || disp_valid[1]) |-> alloc_ready);

    // Retire logic only pops a completed head.
    a_pop_done_only: assert property (@(posedge clk) disable iff (!arst_n)
        head.pop |-> head.head_valid && head.head_done);

    for (genvar p = 0; p < NUM_WB_PORTS; p++) begin : g_match_chk
        a_unique_pc: assert property (@(posedge clk) disable iff (!arst_n)
            $onehot0(pc_match[p]));
    end

endmodule

//--- retire_handshake.sv
// Four-phase req/ack write port for the head of the commit buffer.
// Write fields are registered when req rises and hold until req falls.
// A new req needs ack seen low first; halted blocks any new req.
`timescale 1ns/1ns

module retire_handshake (
    input  logic                 clk,
    input  logic                 arst_n,
    commit_head_if.retire        head,
    input  logic                 halted,
    output logic                 retire_req,
    output logic                 retire_wena,
    output riscv_pkg::reg_addr_t retire_addr,
    output riscv_pkg::data_t     retire_data,
    input  logic                 retire_ack
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_ACK_LOW
    } state_t;

    state_t state_q;
    logic   start;

    assign start    = (state_q == ST_IDLE) & ~retire_ack & head.head_valid
                      & head.head_done & ~halted;
    assign head.pop = (state_q == ST_REQ) & retire_ack;  // One cycle per transfer.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= ST_IDLE;
            retire_req <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q    <= ST_REQ;
                        retire_req <= 1'b1;
                    end
                end
                ST_REQ: begin
                    if (retire_ack) begin
                        state_q    <= ST_ACK_LOW;
                        retire_req <= 1'b0;
                    end
                end
                ST_ACK_LOW: begin
                    if (!retire_ack) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q    <= ST_IDLE;
                    retire_req <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            retire_wena <= head.head_entry.wena;
            retire_addr <= head.head_entry.addr;
            retire_data <= head.head_entry.data;
        end
    end

    a_stable_during_req: assert property (@(posedge clk) disable iff (!arst_n)
        $past(retire_req) && retire_req
        |-> $stable({retire_wena, retire_addr, retire_data}));

endmodule

//--- commit_status_regs.sv
// Retire status: EBREAK trap capture, sticky halt and retired-instruction count.
// halted only clears on reset. The count wraps at 2^32.
`timescale 1ns/1ns

module commit_status_regs (
    input  logic              clk,
    input  logic              arst_n,
    commit_head_if.monitor    head,
    output logic              halted,
    output riscv_pkg::pc_t    halt_pc,
    output riscv_pkg::data_t  exit_code,
    output commit_pkg::count_t retired_count
);

    import riscv_pkg::*;

    logic ebreak_pop;

    assign ebreak_pop = head.pop & (head.head_entry.inst == EBREAK_INST);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted        <= 1'b0;
            halt_pc       <= '0;
            exit_code     <= '0;
            retired_count <= '0;
        end else begin
            if (head.pop) begin
                retired_count <= retired_count + 1'b1;
            end
            if (ebreak_pop) begin
                halted    <= 1'b1;
                halt_pc   <= head.head_entry.pc;
                exit_code <= head.head_entry.data;  // Data of the EBREAK itself.
            end
        end
    end

    // Retire FSM must stop once the trap is latched.
    a_no_pop_halted: assert property (@(posedge clk) disable iff (!arst_n)
        halted |-> !head.pop);

endmodule

//--- commit_top.sv
// Commit buffer top level with plain ports.
// DEPTH must be a power of two, 4 or more.
// Dispatch slot 1 is only valid together with slot 0.
`timescale 1ns/1ns

module commit_top #(
    parameter int DEPTH = commit_pkg::DEFAULT_DEPTH
) (
    input  logic                 clk,
    input  logic                 arst_n,

    input  logic                 disp_valid0,
    input  riscv_pkg::pc_t       disp_pc0,
    input  riscv_pkg::inst_t     disp_inst0,
    input  logic                 disp_valid1,
    input  riscv_pkg::pc_t       disp_pc1,
    input  riscv_pkg::inst_t     disp_inst1,
    output logic                 alloc_ready,

    input  logic                 wb_valid [commit_pkg::NUM_WB_PORTS],
    input  riscv_pkg::pc_t       wb_pc    [commit_pkg::NUM_WB_PORTS],
    input  logic                 wb_wena  [commit_pkg::NUM_WB_PORTS],
    input  riscv_pkg::reg_addr_t wb_addr  [commit_pkg::NUM_WB_PORTS],
    input  riscv_pkg::data_t     wb_data  [commit_pkg::NUM_WB_PORTS],

    output logic                 retire_req,
    output logic                 retire_wena,
    output riscv_pkg::reg_addr_t retire_addr,
    output riscv_pkg::data_t     retire_data,
    input  logic                 retire_ack,

    output logic                 halted,
    output riscv_pkg::pc_t       halt_pc,
    output riscv_pkg::data_t     exit_code,
    output commit_pkg::count_t   retired_count
);

    import riscv_pkg::*;
    import commit_pkg::*;

    logic       disp_valid [2];
    pc_t        disp_pc    [2];
    inst_t      disp_inst  [2];
    wb_result_t wb [NUM_WB_PORTS];

    assign disp_valid = '{disp_valid0, disp_valid1};
    assign disp_pc    = '{disp_pc0, disp_pc1};
    assign disp_inst  = '{disp_inst0, disp_inst1};

    always_comb begin
        for (int p = 0; p < NUM_WB_PORTS; p++) begin
            wb[p] = '{valid: wb_valid[p], pc: wb_pc[p], wena: wb_wena[p],
                      addr: wb_addr[p], data: wb_data[p]};
        end
    end

    commit_head_if head_if ();

    commit_buffer #(
        .DEPTH (DEPTH)
    ) u_buffer (
        .clk         (clk),
        .arst_n      (arst_n),
        .disp_valid  (disp_valid),
        .disp_pc     (disp_pc),
        .disp_inst   (disp_inst),
        .alloc_ready (alloc_ready),
        .wb          (wb),
        .head        (head_if.buffer)
    );

    retire_handshake u_retire (
        .clk         (clk),
        .arst_n      (arst_n),
        .head        (head_if.retire),
        .halted      (halted),
        .retire_req  (retire_req),
        .retire_wena (retire_wena),
        .retire_addr (retire_addr),
        .retire_data (retire_data),
        .retire_ack  (retire_ack)
    );

    commit_status_regs u_status (
        .clk           (clk),
        .arst_n        (arst_n),
        .head          (head_if.monitor),
        .halted        (halted),
        .halt_pc       (halt_pc),
        .exit_code     (exit_code),
        .retired_count (retired_count)
    );

endmodule

//--- tb_commit_top.sv
// Testbench for commit_top with DEPTH 8. Stimulus comes from a Galois LFSR.
// Inputs change on the falling edge; concurrent assertions check at the rising edge
// against a reference queue that is kept in dispatch order.
// The EBREAK test runs last, since halted only clears on reset.
`timescale 1ns/1ns

module tb_commit_top;

    import riscv_pkg::*;
    import commit_pkg::*;

    localparam int DEPTH      = 8;
    localparam int LONG_BITS  = 4;  // Long ack delays of 0 to 15 cycles.
    localparam int N_SHUFFLE  = 40;
    localparam int N_LONG     = 24;
    localparam int N_FILL     = 2 * DEPTH;
    localparam int N_EBREAK   = 6;
    localparam int MAX_CYCLES = (N_SHUFFLE + N_LONG + N_FILL + N_EBREAK)
                                * (2 * (1 << LONG_BITS) + 6) + 500;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    typedef struct packed {
        pc_t       pc;
        inst_t     inst;
        logic      wena;
        reg_addr_t addr;
        data_t     data;
    } ref_t;

    logic      clk;
    logic      arst_n;
    logic      disp_valid0;
    pc_t       disp_pc0;
    inst_t     disp_inst0;
    logic      disp_valid1;
    pc_t       disp_pc1;
    inst_t     disp_inst1;
    logic      alloc_ready;
    logic      wb_valid [NUM_WB_PORTS];
    pc_t       wb_pc    [NUM_WB_PORTS];
    logic      wb_wena  [NUM_WB_PORTS];
    reg_addr_t wb_addr  [NUM_WB_PORTS];
    data_t     wb_data  [NUM_WB_PORTS];
    logic      retire_req;
    logic      retire_wena;
    reg_addr_t retire_addr;
    data_t     retire_data;
    logic      retire_ack;
    logic      halted;
    pc_t       halt_pc;
    data_t     exit_code;
    count_t    retired_count;

    logic [31:0] lfsr_state = 32'd50;
    ref_t        ref_q[$];     // Dispatched, not yet retired.
    ref_t        open_q[$];    // Allocated, not yet completed.
    ref_t        staged_q[$];  // Driven this cycle, allocated at the next edge.
    pc_t         next_pc     = 64'h8000_0000;
    int          in_flight   = 0;
    int          hs_count    = 0;
    int          disp_count  = 0;
    int          disp_limit  = 0;
    int          ebreak_seq  = -1;
    int          delay_bits  = 1;
    int          ack_wait    = 0;
    int          drop_wait   = 0;
    logic        hold_ack    = 1'b0;
    logic        req_seen    = 1'b0;
    logic        exp_valid   = 1'b0;
    logic        exp_wena    = 1'b0;
    reg_addr_t   exp_addr    = '0;
    data_t       exp_data    = '0;
    pc_t         exp_halt_pc = '0;
    data_t       exp_exit    = '0;
    int          errors      = 0;
    int          err_base    = 0;
    int          test_num    = 0;
    int          cycles      = 0;

    commit_top #(.DEPTH(DEPTH)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Checks failed");
        $finish;
    end

    function automatic logic lfsr_bit();
        logic lsb;
        lsb        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return lsb;
    endfunction

    function automatic logic [63:0] lfsr_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Advance to the falling edge, account for the rising edge just passed, run the ack side.
    task automatic tick();
        logic fell;
        @(negedge clk);
        fell = req_seen && !retire_req;
        if (retire_req && !req_seen) begin
            ack_wait = int'(lfsr_bits(delay_bits));
        end
        req_seen  = retire_req;
        in_flight = in_flight + staged_q.size();
        foreach (staged_q[i]) begin
            open_q.push_back(staged_q[i]);
        end
        staged_q.delete();
        if (fell) begin  // Pop happened at the ack edge.
            void'(ref_q.pop_front());
            in_flight--;
            hs_count++;
            drop_wait = int'(lfsr_bits(delay_bits));
        end
        exp_valid = (ref_q.size() != 0);
        if (exp_valid) begin
            exp_wena = ref_q[0].wena;
            exp_addr = ref_q[0].addr;
            exp_data = ref_q[0].data;
        end
        if (retire_req && !retire_ack && !hold_ack) begin
            if (ack_wait == 0) begin
                retire_ack = 1'b1;
            end else begin
                ack_wait--;
            end
        end
        if (!retire_req && retire_ack) begin  // Ack lingers after req falls.
            if (drop_wait == 0) begin
                retire_ack = 1'b0;
            end else begin
                drop_wait--;
            end
        end
        disp_valid0 = 1'b0;
        disp_valid1 = 1'b0;
        for (int p = 0; p < NUM_WB_PORTS; p++) begin
            wb_valid[p] = 1'b0;
        end
    endtask

    task automatic dispatch_some();
        logic [1:0] pick;
        int         n;
        ref_t       r;
        if (!alloc_ready || disp_count >= disp_limit) begin
            return;
        end
        pick = 2'(lfsr_bits(2));
        n    = int'(pick[0]) + int'(pick[1]);
        if (n > disp_limit - disp_count) begin
            n = disp_limit - disp_count;
        end
        for (int s = 0; s < n; s++) begin
            r.pc   = next_pc;
            r.wena = lfsr_bit();
            r.addr = reg_addr_t'(lfsr_bits(REG_ADDR_W));
            r.data = lfsr_bits(XLEN);
            r.inst = {12'h001, 5'd0, 3'd0, r.addr, 7'h13};  // ADDI rd, x0, 1.
            if (disp_count == ebreak_seq) begin
                r.inst      = EBREAK_INST;
                exp_halt_pc = r.pc;
                exp_exit    = r.data;
            end
            next_pc = next_pc + 64'd4;
            disp_count++;
            ref_q.push_back(r);
            staged_q.push_back(r);
            if (s == 0) begin
                disp_valid0 = 1'b1;
                disp_pc0    = r.pc;
                disp_inst0  = r.inst;
            end else begin
                disp_valid1 = 1'b1;
                disp_pc1    = r.pc;
                disp_inst1  = r.inst;
            end
        end
    endtask

    // Random outstanding entries on random ports, so completion order is shuffled.
    task automatic complete_some();
        int idx;
        for (int p = 0; p < NUM_WB_PORTS; p++) begin
            if (open_q.size() != 0 && lfsr_bit()) begin
                idx         = int'(lfsr_bits(4)) % open_q.size();
                wb_valid[p] = 1'b1;
                wb_pc[p]    = open_q[idx].pc;
                wb_wena[p]  = open_q[idx].wena;
                wb_addr[p]  = open_q[idx].addr;
                wb_data[p]  = open_q[idx].data;
                open_q.delete(idx);
            end
        end
    endtask

    task automatic run_until_drained(input int n);
        disp_limit = disp_count + n;
        while (disp_count < disp_limit || ref_q.size() != 0) begin
            tick();
            dispatch_some();
            complete_some();
        end
    endtask

    task automatic report_test(input string name);
        test_num++;
        $display("test %0d %s done, %0d errors", test_num, name, errors - err_base);
        err_base = errors;
    endtask

    a_reset_state: assert property (@(posedge clk) $rose(arst_n)
        |-> !retire_req && alloc_ready && !halted && retired_count == '0)
        else begin
            $display("error reset state: retire_req=0x%h alloc_ready=0x%h halted=0x%h count=0x%h",
                     retire_req, $sampled(alloc_ready), halted, retired_count);
            errors++;
        end

    a_retire_order: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(retire_req) |-> exp_valid && retire_wena == exp_wena
                              && retire_addr == exp_addr && retire_data == exp_data)
        else begin
            $display("error retire_wena/retire_addr/retire_data: got 0x%h/0x%h/0x%h,",
                     retire_wena, retire_addr, retire_data);
            $display("error    expected 0x%h/0x%h/0x%h", exp_wena, exp_addr, exp_data);
            errors++;
        end

    a_hold_fields: assert property (@(posedge clk) disable iff (!arst_n)
        retire_req && $past(retire_req) |-> $stable({retire_wena, retire_addr, retire_data}))
        else begin
            $display("retire write fields changed while retire_req was high");
            errors++;
        end

    a_fall_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(retire_req) |-> $past(retire_ack))
        else begin
            $display("retire_req fell before retire_ack was seen");
            errors++;
        end

    a_rise_after_ack_low: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(retire_req) |-> !$past(retire_ack))
        else begin
            $display("retire_req rose before retire_ack was seen low");
            errors++;
        end

    a_halt_blocks_req: assert property (@(posedge clk) disable iff (!arst_n)
        $past(halted) |-> !$rose(retire_req))
        else begin
            $display("retire_req rose after the core halted");
            errors++;
        end

    a_alloc_ready: assert property (@(posedge clk) disable iff (!arst_n)
        alloc_ready == (in_flight <= DEPTH - 2))
        else begin
            $display("error alloc_ready: got 0x%h, expected 0x%h with %0d entries in use",
                     $sampled(alloc_ready), $sampled(in_flight) <= DEPTH - 2,
                     $sampled(in_flight));
            errors++;
        end

    a_retired_count: assert property (@(posedge clk) disable iff (!arst_n)
        retired_count == count_t'(hs_count))
        else begin
            $display("error retired_count: got 0x%h, expected 0x%h",
                     $sampled(retired_count), $sampled(hs_count));
            errors++;
        end

    a_halt_pc: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(halted) |-> halt_pc == exp_halt_pc)
        else begin
            $display("error halt_pc: got 0x%h, expected 0x%h", halt_pc, exp_halt_pc);
            errors++;
        end

    a_exit_code: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(halted) |-> exit_code == exp_exit)
        else begin
            $display("error exit_code: got 0x%h, expected 0x%h", exit_code, exp_exit);
            errors++;
        end

    initial begin
        arst_n      = 1'b0;
        retire_ack  = 1'b0;
        disp_valid0 = 1'b0;
        disp_pc0    = '0;
        disp_inst0  = '0;
        disp_valid1 = 1'b0;
        disp_pc1    = '0;
        disp_inst1  = '0;
        for (int p = 0; p < NUM_WB_PORTS; p++) begin
            wb_valid[p] = 1'b0;
            wb_pc[p]    = '0;
            wb_wena[p]  = 1'b0;
            wb_addr[p]  = '0;
            wb_data[p]  = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(posedge clk);  // a_reset_state fires here.
        @(negedge clk);
        report_test("reset state");

        delay_bits = 1;
        run_until_drained(N_SHUFFLE);
        report_test("shuffled completion");

        delay_bits = LONG_BITS;
        run_until_drained(N_LONG);
        report_test("long ack delays");

        // Hold ack so the head blocks and the buffer fills.
        delay_bits = 1;
        hold_ack   = 1'b1;
        disp_limit = disp_count + N_FILL;
        while (alloc_ready && disp_count < disp_limit) begin
            tick();
            dispatch_some();
            complete_some();
        end
        disp_limit = disp_count;
        assert (!alloc_ready) else begin
            $display("buffer never filled while retire_ack was withheld");
            errors++;
        end
        repeat (DEPTH) begin
            tick();
            complete_some();
        end
        hold_ack = 1'b0;
        run_until_drained(0);
        assert (hs_count == disp_count) else begin
            $display("%0d instructions dispatched but %0d transfers seen", disp_count, hs_count);
            errors++;
        end
        report_test("back-pressure");

        ebreak_seq = disp_count + 3;
        disp_limit = disp_count + N_EBREAK;
        while (disp_count < disp_limit || staged_q.size() != 0 || open_q.size() != 0
               || !halted) begin
            tick();
            dispatch_some();
            complete_some();
        end
        repeat (20) tick();
        assert (hs_count == ebreak_seq + 1) else begin
            $display("transfers continued or stopped early around the EBREAK");
            errors++;
        end
        report_test("ebreak halt");

        $display("summary: %0d tests, %0d transfers, %0d errors", test_num, hs_count, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- sources.f
riscv_pkg.sv
commit_pkg.sv
commit_head_if.sv
commit_buffer.sv
retire_handshake.sv
commit_status_regs.sv
commit_top.sv
tb_commit_top.sv

//--- Bender.yml
package:
  name: commit_buffer

sources:
  - riscv_pkg.sv
  - commit_pkg.sv
  - commit_head_if.sv
  - commit_buffer.sv
  - retire_handshake.sv
  - commit_status_regs.sv
  - commit_top.sv
  - target: test
    files:
      - tb_commit_top.sv
